// ==== design/bert_config.svh ====
`ifndef BERT_CONFIG_SVH
`define BERT_CONFIG_SVH

////////////////////
// Management bus

// Register bus address width
`define BERT_ADDR_W 16

// Register bus data width, one byte per register
`define BERT_DATA_W 8

////////////////////
// Transceiver DRP

// DRP address, nine bits on the GTX
`define BERT_DRP_ADDR_W 9

// DRP data word
`define BERT_DRP_DATA_W 16

// Address bits 15:6 that select the lane window 0x0080-0x00BF
`define BERT_WINDOW_PAGE 10'h002

`endif

// ==== design/bert_pkg.sv ====
`default_nettype none

`include "bert_config.svh"

package bert_pkg;

	////////////////////
	// Address decode

	// One bus address seen either whole or split into window fields
	typedef union packed {
		logic [`BERT_ADDR_W-1:0] raw;
		struct packed {
			// Compared against the window page
			logic [9:0] page;
			// Lane 0 at 0x0080, lane 1 at 0x00A0
			logic       lane;
			// Register within the lane
			logic [4:0] offset;
		} fields;
	} reg_addr_u;

	// Register offsets within one lane
	typedef enum logic [4:0] {
		PRBS  = 5'h00,
		TX    = 5'h02,
		TX_HI = 5'h03,
		WD    = 5'h04,
		WD_HI = 5'h05,
		AD    = 5'h06,
		AD_HI = 5'h07,
		RD    = 5'h08,
		RD_HI = 5'h09,
		STAT  = 5'h0A,
		CLK   = 5'h0C,
		RST   = 5'h0E,
		RX    = 5'h10
	} lane_reg_e;

	////////////////////
	// Lane configuration

	// TX side of one lane
	typedef struct packed {
		logic       invert;
		logic       enable;
		logic [4:0] postcursor;
		logic [4:0] precursor;
		logic [3:0] swing;
		logic [2:0] prbsmode;
		logic [2:0] clkdiv;
		logic       clk_from_qpll;
		logic       tx_reset;
	} tx_config_t;

	// RX side of one lane
	typedef struct packed {
		logic       invert;
		logic [2:0] prbsmode;
		logic [2:0] clkdiv;
		logic       clk_from_qpll;
		logic       pmareset;
		logic       rx_reset;
	} rx_config_t;

endpackage

`default_nettype wire

// ==== design/reg_access_if.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "bert_config.svh"

// One decoded register access, one cycle behind the bus
interface reg_access_if;
	logic                    strobe;
	logic                    hit;
	logic                    lane;
	bert_pkg::lane_reg_e     offset;
	logic [`BERT_DATA_W-1:0] data;

	modport source (output strobe, hit, lane, offset, data);
	modport sink   (input strobe, hit, lane, offset, data);
endinterface

`default_nettype wire

// ==== design/reg_bus_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "bert_config.svh"

module reg_bus_decoder (
	input wire                    clk,
	input wire                    rst,
	input wire                    rd_en,
	input wire [`BERT_ADDR_W-1:0] rd_addr,
	input wire                    wr_en,
	input wire [`BERT_ADDR_W-1:0] wr_addr,
	input wire [`BERT_DATA_W-1:0] wr_data,
	reg_access_if.source          wr_acc,
	reg_access_if.source          rd_acc
);

	////////////////////
	// Address views

	bert_pkg::reg_addr_u wr_view;
	bert_pkg::reg_addr_u rd_view;
	logic                wr_in_window;
	logic                rd_in_window;

	assign wr_view.raw = wr_addr;
	assign rd_view.raw = rd_addr;

	// Window hit from the page bits alone
	assign wr_in_window = (wr_view.fields.page == `BERT_WINDOW_PAGE);
	assign rd_in_window = (rd_view.fields.page == `BERT_WINDOW_PAGE);

	////////////////////
	// Strobes

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_acc.strobe <= 1'b0;
			wr_acc.hit    <= 1'b0;
			rd_acc.strobe <= 1'b0;
			rd_acc.hit    <= 1'b0;
		end else begin
			// Writes outside the window stop here
			wr_acc.strobe <= wr_en && wr_in_window;
			wr_acc.hit    <= wr_en && wr_in_window;
			// Every read gets answered, misses with zero
			rd_acc.strobe <= rd_en;
			rd_acc.hit    <= rd_en && rd_in_window;
		end
	end

	// Lane, offset and data only move with a request
	always_ff @(posedge clk) begin
		if (wr_en) begin
			wr_acc.lane   <= wr_view.fields.lane;
			wr_acc.offset <= bert_pkg::lane_reg_e'(wr_view.fields.offset);
			wr_acc.data   <= wr_data;
		end
		if (rd_en) begin
			rd_acc.lane   <= rd_view.fields.lane;
			rd_acc.offset <= bert_pkg::lane_reg_e'(rd_view.fields.offset);
		end
	end

	// Read side carries no data
	assign rd_acc.data = '0;

endmodule

`default_nettype wire

// ==== design/lane_config_bank.sv ====
`timescale 1ns/1ns
`default_nettype none

module lane_config_bank (
	input wire                     clk,
	input wire                     rst,
	reg_access_if.sink             wr_acc,
	output logic                   serdes_config_updated,
	output bert_pkg::tx_config_t   tx0_config,
	output bert_pkg::tx_config_t   tx1_config,
	output bert_pkg::rx_config_t   rx0_config,
	output bert_pkg::rx_config_t   rx1_config
);

	// Per-lane copies, indexed by the decoded lane bit
	bert_pkg::tx_config_t tx_cfg [2];
	bert_pkg::rx_config_t rx_cfg [2];

	////////////////////
	// Register writes

	always_ff @(posedge clk) begin
		// Update flag is a single-cycle pulse
		serdes_config_updated <= 1'b0;

		if (rst) begin
			for (int i = 0; i < 2; i++) begin
				tx_cfg[i] <= '0;
				rx_cfg[i] <= '0;
			end
		end else if (wr_acc.strobe) begin
			case (wr_acc.offset)
				// RX PRBS low nibble, TX PRBS high nibble
				bert_pkg::PRBS: begin
					rx_cfg[wr_acc.lane].prbsmode <= wr_acc.data[2:0];
					tx_cfg[wr_acc.lane].prbsmode <= wr_acc.data[6:4];
					serdes_config_updated        <= 1'b1;
				end
				// Low half of the drive word, takes effect with TX_HI
				bert_pkg::TX: begin
					tx_cfg[wr_acc.lane].swing          <= wr_acc.data[3:0];
					tx_cfg[wr_acc.lane].precursor[3:0] <= wr_acc.data[7:4];
				end
				bert_pkg::TX_HI: begin
					tx_cfg[wr_acc.lane].precursor[4] <= wr_acc.data[0];
					tx_cfg[wr_acc.lane].postcursor   <= wr_acc.data[5:1];
					tx_cfg[wr_acc.lane].enable       <= wr_acc.data[6];
					tx_cfg[wr_acc.lane].invert       <= wr_acc.data[7];
					serdes_config_updated            <= 1'b1;
				end
				// Dividers and PLL choice, TX in the low nibble
				bert_pkg::CLK: begin
					tx_cfg[wr_acc.lane].clkdiv        <= wr_acc.data[2:0];
					tx_cfg[wr_acc.lane].clk_from_qpll <= wr_acc.data[3];
					rx_cfg[wr_acc.lane].clkdiv        <= wr_acc.data[6:4];
					rx_cfg[wr_acc.lane].clk_from_qpll <= wr_acc.data[7];
					serdes_config_updated             <= 1'b1;
				end
				// Soft resets, held until written back to zero
				bert_pkg::RST: begin
					rx_cfg[wr_acc.lane].pmareset <= wr_acc.data[0];
					tx_cfg[wr_acc.lane].tx_reset <= wr_acc.data[1];
					rx_cfg[wr_acc.lane].rx_reset <= wr_acc.data[2];
					serdes_config_updated        <= 1'b1;
				end
				bert_pkg::RX: begin
					rx_cfg[wr_acc.lane].invert <= wr_acc.data[0];
					serdes_config_updated      <= 1'b1;
				end
				// DRP registers belong to the bridge
				default: begin
				end
			endcase
		end
	end

	////////////////////
	// Outputs

	assign tx0_config = tx_cfg[0];
	assign tx1_config = tx_cfg[1];
	assign rx0_config = rx_cfg[0];
	assign rx1_config = rx_cfg[1];

endmodule

`default_nettype wire

// ==== design/drp_bridge.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "bert_config.svh"

module drp_bridge (
	input wire                          clk,
	input wire                          rst,
	input wire                          drp_lane0_done,
	input wire                          drp_lane1_done,
	reg_access_if.sink                  wr_acc,
	output logic                        drp_lane0_en,
	output logic                        drp_lane1_en,
	output logic                        drp_we,
	output logic [`BERT_DRP_ADDR_W-1:0] drp_addr,
	output logic [`BERT_DRP_DATA_W-1:0] drp_wdata,
	output logic [1:0]                  drp_busy
);

	// Start pulses, bit per lane
	logic [1:0] start;
	logic [1:0] done;

	assign done = {drp_lane1_done, drp_lane0_done};

	////////////////////
	// Command registers

	// Address and data are shared, only the start picks the lane
	always_ff @(posedge clk) begin
		start <= 2'b00;

		if (rst) begin
			drp_we    <= 1'b0;
			drp_addr  <= '0;
			drp_wdata <= '0;
		end else if (wr_acc.strobe) begin
			case (wr_acc.offset)
				bert_pkg::WD:    drp_wdata[7:0]  <= wr_acc.data;
				bert_pkg::WD_HI: drp_wdata[15:8] <= wr_acc.data;
				bert_pkg::AD:    drp_addr[7:0]   <= wr_acc.data;
				// High address byte launches the transaction
				bert_pkg::AD_HI: begin
					start[wr_acc.lane] <= 1'b1;
					drp_we             <= wr_acc.data[7];
					drp_addr[8]        <= wr_acc.data[0];
				end
				default: begin
				end
			endcase
		end
	end

	// Busy from start until done, done wins a tie
	always_ff @(posedge clk) begin
		if (rst)
			drp_busy <= 2'b00;
		else
			drp_busy <= (drp_busy | start) & ~done;
	end

	assign drp_lane0_en = start[0];
	assign drp_lane1_en = start[1];

endmodule

`default_nettype wire

// ==== design/readback_mux.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "bert_config.svh"

module readback_mux (
	input wire                         clk,
	input wire                         rst,
	input wire [`BERT_DRP_DATA_W-1:0]  drp_lane0_rdata,
	input wire [`BERT_DRP_DATA_W-1:0]  drp_lane1_rdata,
	input wire                         lane0_rx_rstdone,
	input wire                         lane1_rx_rstdone,
	input wire [1:0]                   drp_busy,
	reg_access_if.sink                 rd_acc,
	output logic                       rd_valid,
	output logic [`BERT_DATA_W-1:0]    rd_data
);

	logic [`BERT_DRP_DATA_W-1:0] lane_rdata;
	logic                        lane_rstdone;
	logic [`BERT_DATA_W-1:0]     rd_byte;

	////////////////////
	// Byte select

	always_comb begin
		// Pick the addressed lane first
		lane_rdata   = rd_acc.lane ? drp_lane1_rdata : drp_lane0_rdata;
		lane_rstdone = rd_acc.lane ? lane1_rx_rstdone : lane0_rx_rstdone;

		// Misses and write-only registers read back zero
		rd_byte = '0;
		if (rd_acc.hit) begin
			case (rd_acc.offset)
				bert_pkg::RD:    rd_byte = lane_rdata[7:0];
				bert_pkg::RD_HI: rd_byte = lane_rdata[15:8];
				bert_pkg::STAT:  rd_byte = {6'b0, lane_rstdone, drp_busy[rd_acc.lane]};
				default:         rd_byte = '0;
			endcase
		end
	end

	// One result per read strobe, data held between reads
	always_ff @(posedge clk) begin
		if (rst) begin
			rd_valid <= 1'b0;
			rd_data  <= '0;
		end else begin
			rd_valid <= rd_acc.strobe;
			if (rd_acc.strobe)
				rd_data <= rd_byte;
		end
	end

endmodule

`default_nettype wire

// ==== design/bert_mgmt_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "bert_config.svh"

module bert_mgmt_top (
	input wire                          clk,
	input wire                          rst,

	// Management register bus
	input wire                          rd_en,
	input wire [`BERT_ADDR_W-1:0]       rd_addr,
	output logic                        rd_valid,
	output logic [`BERT_DATA_W-1:0]     rd_data,
	input wire                          wr_en,
	input wire [`BERT_ADDR_W-1:0]       wr_addr,
	input wire [`BERT_DATA_W-1:0]       wr_data,

	// Lane configuration
	output logic                        serdes_config_updated,
	output bert_pkg::tx_config_t        tx0_config,
	output bert_pkg::tx_config_t        tx1_config,
	output bert_pkg::rx_config_t        rx0_config,
	output bert_pkg::rx_config_t        rx1_config,

	// Transceiver DRP
	output logic                        drp_lane0_en,
	output logic                        drp_lane1_en,
	output logic                        drp_we,
	output logic [`BERT_DRP_ADDR_W-1:0] drp_addr,
	output logic [`BERT_DRP_DATA_W-1:0] drp_wdata,
	input wire [`BERT_DRP_DATA_W-1:0]   drp_lane0_rdata,
	input wire [`BERT_DRP_DATA_W-1:0]   drp_lane1_rdata,
	input wire                          drp_lane0_done,
	input wire                          drp_lane1_done,
	input wire                          lane0_rx_rstdone,
	input wire                          lane1_rx_rstdone
);

	// Decoded accesses, writes to the bank and bridge, reads to the mux
	reg_access_if wr_acc ();
	reg_access_if rd_acc ();

	// Busy flags cross from the bridge into the status byte
	logic [1:0] drp_busy;

	////////////////////
	// Bus input

	reg_bus_decoder i_decoder (
		.clk     (clk),
		.rst     (rst),
		.rd_en   (rd_en),
		.rd_addr (rd_addr),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.wr_acc  (wr_acc.source),
		.rd_acc  (rd_acc.source)
	);

	////////////////////
	// Register holders

	lane_config_bank i_bank (
		.clk                   (clk),
		.rst                   (rst),
		.wr_acc                (wr_acc.sink),
		.serdes_config_updated (serdes_config_updated),
		.tx0_config            (tx0_config),
		.tx1_config            (tx1_config),
		.rx0_config            (rx0_config),
		.rx1_config            (rx1_config)
	);

	drp_bridge i_drp (
		.clk            (clk),
		.rst            (rst),
		.drp_lane0_done (drp_lane0_done),
		.drp_lane1_done (drp_lane1_done),
		.wr_acc         (wr_acc.sink),
		.drp_lane0_en   (drp_lane0_en),
		.drp_lane1_en   (drp_lane1_en),
		.drp_we         (drp_we),
		.drp_addr       (drp_addr),
		.drp_wdata      (drp_wdata),
		.drp_busy       (drp_busy)
	);

	////////////////////
	// Read output

	readback_mux i_readback (
		.clk              (clk),
		.rst              (rst),
		.drp_lane0_rdata  (drp_lane0_rdata),
		.drp_lane1_rdata  (drp_lane1_rdata),
		.lane0_rx_rstdone (lane0_rx_rstdone),
		.lane1_rx_rstdone (lane1_rx_rstdone),
		.drp_busy         (drp_busy),
		.rd_acc           (rd_acc.sink),
		.rd_valid         (rd_valid),
		.rd_data          (rd_data)
	);

endmodule

`default_nettype wire

// ==== verif/bert_mgmt_sva.sv ====
`timescale 1ns/1ns
`default_nettype none

// Protocol checks on the management block, bound into the top level
module bert_mgmt_sva (
	input wire clk,
	input wire rst,
	input wire rd_en,
	input wire rd_valid,
	input wire serdes_config_updated,
	input wire drp_lane0_en,
	input wire drp_lane1_en,
	input wire drp_we
);

	// Number of failed assertions so far
	int failures = 0;

	////////////////////
	// Read latency

	// Each read answers exactly two cycles later
	a_rd_follows_en: assert property (
		@(posedge clk) disable iff (rst) rd_en |-> ##2 rd_valid)
		else begin
			$error("rd_valid missing two cycles after rd_en");
			failures++;
		end

	// And nothing answers without a read
	a_rd_has_en: assert property (
		@(posedge clk) disable iff (rst) rd_valid |-> $past(rd_en, 2))
		else begin
			$error("rd_valid without rd_en two cycles before");
			failures++;
		end

	////////////////////
	// DRP and reset

	// One shared DRP address, so one lane starts at a time
	a_one_start: assert property (
		@(posedge clk) disable iff (rst) !(drp_lane0_en && drp_lane1_en))
		else begin
			$error("both DRP start pulses high together");
			failures++;
		end

	// Control outputs idle in the cycle after a reset edge
	a_reset_idle: assert property (
		@(posedge clk) rst |=> !rd_valid && !serdes_config_updated
			&& !drp_lane0_en && !drp_lane1_en && !drp_we)
		else begin
			$error("control output high after reset");
			failures++;
		end

endmodule

bind bert_mgmt_top bert_mgmt_sva i_sva (
	.clk                   (clk),
	.rst                   (rst),
	.rd_en                 (rd_en),
	.rd_valid              (rd_valid),
	.serdes_config_updated (serdes_config_updated),
	.drp_lane0_en          (drp_lane0_en),
	.drp_lane1_en          (drp_lane1_en),
	.drp_we                (drp_we)
);

`default_nettype wire

// ==== verif/bert_mgmt_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "bert_config.svh"

module bert_mgmt_tb;

	////////////////////
	// DUT signals

	logic                        clk = 1'b0;
	logic                        rst;
	logic                        rd_en;
	logic [`BERT_ADDR_W-1:0]     rd_addr;
	logic                        rd_valid;
	logic [`BERT_DATA_W-1:0]     rd_data;
	logic                        wr_en;
	logic [`BERT_ADDR_W-1:0]     wr_addr;
	logic [`BERT_DATA_W-1:0]     wr_data;
	logic                        serdes_config_updated;
	bert_pkg::tx_config_t        tx0_config;
	bert_pkg::tx_config_t        tx1_config;
	bert_pkg::rx_config_t        rx0_config;
	bert_pkg::rx_config_t        rx1_config;
	logic                        drp_lane0_en;
	logic                        drp_lane1_en;
	logic                        drp_we;
	logic [`BERT_DRP_ADDR_W-1:0] drp_addr;
	logic [`BERT_DRP_DATA_W-1:0] drp_wdata;
	logic [`BERT_DRP_DATA_W-1:0] drp_lane0_rdata;
	logic [`BERT_DRP_DATA_W-1:0] drp_lane1_rdata;
	logic                        drp_lane0_done;
	logic                        drp_lane1_done;
	logic                        lane0_rx_rstdone;
	logic                        lane1_rx_rstdone;

	// 8 ns clock
	always #4 clk = ~clk;

	bert_mgmt_top i_bert_mgmt_top (.*);

	////////////////////
	// Reference model

	// One cycle of bus requests as driven
	typedef struct packed {
		logic                    rd;
		logic [`BERT_ADDR_W-1:0] raddr;
		logic                    wr;
		logic [`BERT_ADDR_W-1:0] waddr;
		logic [`BERT_DATA_W-1:0] wdata;
	} bus_req_t;

	// Requests of the last two cycles, answers come two cycles after driving
	bus_req_t                    pend [2];
	logic [`BERT_DATA_W-1:0]     rd_expect [$];
	bert_pkg::tx_config_t        m_tx [2];
	bert_pkg::rx_config_t        m_rx [2];
	logic                        m_upd;
	logic [1:0]                  m_start;
	logic [1:0]                  m_busy;
	logic                        m_we;
	logic [`BERT_DRP_ADDR_W-1:0] m_addr;
	logic [`BERT_DRP_DATA_W-1:0] m_wdata;
	// Start and done of the previous cycle feed the busy flags
	logic [1:0]                  start_last;
	logic [1:0]                  done_last;
	// DRP responder countdown per lane
	int                          resp_cnt [2];
	// Last answered read, for polling
	logic                        rd_seen;
	logic [`BERT_DATA_W-1:0]     rd_last;
	logic [4:0]                  reg_offsets [13] = '{5'h00, 5'h02, 5'h03, 5'h04, 5'h05,
		5'h06, 5'h07, 5'h08, 5'h09, 5'h0A, 5'h0C, 5'h0E, 5'h10};

	// Lane window 0x0080-0x00BF, lane 1 from 0x00A0
	function automatic logic in_window(input logic [`BERT_ADDR_W-1:0] addr);
		return (addr >= 16'h0080) && (addr <= 16'h00BF);
	endfunction

	// Mostly mapped lane registers, some unmapped, some outside the window
	function automatic logic [`BERT_ADDR_W-1:0] pick_addr();
		logic [`BERT_ADDR_W-1:0] addr;
		logic                    lane;
		logic [4:0]              off;
		int                      kind;
		lane = 1'($urandom);
		if ($urandom_range(0, 3) == 0)
			off = 5'($urandom);
		else
			off = reg_offsets[$urandom_range(0, 12)];
		addr = 16'h0080 + {lane, off};
		kind = $urandom_range(0, 15);
		// Neighbour pages 0x0040-0x007F
		if (kind == 0)
			addr = addr ^ 16'h00C0;
		if (kind == 1) begin
			addr = 16'($urandom);
			if (in_window(addr))
				addr = addr ^ 16'h0100;
		end
		return addr;
	endfunction

	// Register write effects by the lane register map
	task automatic apply_write(input bus_req_t req);
		logic                    l;
		logic [`BERT_DATA_W-1:0] d;
		l       = req.waddr[5];
		d       = req.wdata;
		m_upd   = 1'b0;
		m_start = 2'b00;
		if (req.wr && in_window(req.waddr)) begin
			case (req.waddr[4:0])
				bert_pkg::PRBS: begin
					m_rx[l].prbsmode = d[2:0];
					m_tx[l].prbsmode = d[6:4];
					m_upd            = 1'b1;
				end
				bert_pkg::TX: begin
					m_tx[l].swing          = d[3:0];
					m_tx[l].precursor[3:0] = d[7:4];
				end
				bert_pkg::TX_HI: begin
					m_tx[l].precursor[4] = d[0];
					m_tx[l].postcursor   = d[5:1];
					m_tx[l].enable       = d[6];
					m_tx[l].invert       = d[7];
					m_upd                = 1'b1;
				end
				bert_pkg::CLK: begin
					m_tx[l].clkdiv        = d[2:0];
					m_tx[l].clk_from_qpll = d[3];
					m_rx[l].clkdiv        = d[6:4];
					m_rx[l].clk_from_qpll = d[7];
					m_upd                 = 1'b1;
				end
				bert_pkg::RST: begin
					m_rx[l].pmareset = d[0];
					m_tx[l].tx_reset = d[1];
					m_rx[l].rx_reset = d[2];
					m_upd            = 1'b1;
				end
				bert_pkg::RX: begin
					m_rx[l].invert = d[0];
					m_upd          = 1'b1;
				end
				// Shared DRP data and address, AD_HI starts the lane
				bert_pkg::WD:    m_wdata[7:0]  = d;
				bert_pkg::WD_HI: m_wdata[15:8] = d;
				bert_pkg::AD:    m_addr[7:0]   = d;
				bert_pkg::AD_HI: begin
					m_start[l] = 1'b1;
					m_we       = d[7];
					m_addr[8]  = d[0];
				end
				default: begin
				end
			endcase
		end
	endtask

	// Read byte from the current inputs and busy flags
	function automatic logic [`BERT_DATA_W-1:0] expect_read(input logic [`BERT_ADDR_W-1:0] addr);
		logic [`BERT_DRP_DATA_W-1:0] rdata;
		logic                        rstdone;
		rdata   = addr[5] ? drp_lane1_rdata : drp_lane0_rdata;
		rstdone = addr[5] ? lane1_rx_rstdone : lane0_rx_rstdone;
		if (!in_window(addr))
			return 8'h00;
		case (addr[4:0])
			bert_pkg::RD:    return rdata[7:0];
			bert_pkg::RD_HI: return rdata[15:8];
			bert_pkg::STAT:  return {6'b0, rstdone, m_busy[addr[5]]};
			default:         return 8'h00;
		endcase
	endfunction

	////////////////////
	// Compare tasks

	task automatic stop_on_mismatch(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		$display("MISMATCH at %0t ns: %s expected %h, got %h", $time, name, exp, act);
		$display("test failed");
		$fatal(1);
	endtask

	task automatic stop_on_timeout(input string what);
		$display("Timeout at %0t ns: %s", $time, what);
		$display("test failed");
		$fatal(1);
	endtask

	task automatic check_tx(input string name, input bert_pkg::tx_config_t exp,
			input bert_pkg::tx_config_t act);
		if (act !== exp)
			stop_on_mismatch(name, exp, act);
	endtask

	task automatic check_rx(input string name, input bert_pkg::rx_config_t exp,
			input bert_pkg::rx_config_t act);
		if (act !== exp)
			stop_on_mismatch(name, exp, act);
	endtask

	task automatic check_byte(input string name, input logic [`BERT_DATA_W-1:0] exp,
			input logic [`BERT_DATA_W-1:0] act);
		if (act !== exp)
			stop_on_mismatch(name, exp, act);
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp)
			stop_on_mismatch(name, exp, act);
	endtask

	task automatic check_drp(input logic [`BERT_DRP_ADDR_W-1:0] exp_addr,
			input logic [`BERT_DRP_DATA_W-1:0] exp_wdata, input logic exp_we);
		if (drp_addr !== exp_addr)
			stop_on_mismatch("drp_addr", exp_addr, drp_addr);
		if (drp_wdata !== exp_wdata)
			stop_on_mismatch("drp_wdata", exp_wdata, drp_wdata);
		if (drp_we !== exp_we)
			stop_on_mismatch("drp_we", exp_we, drp_we);
	endtask

	////////////////////
	// Cycle step

	// Check after the edge, run the responder, then drive the next request
	task automatic run_cycle(input logic do_rd, input logic [`BERT_ADDR_W-1:0] raddr,
			input logic do_wr, input logic [`BERT_ADDR_W-1:0] waddr,
			input logic [`BERT_DATA_W-1:0] wdata);
		bus_req_t                req;
		logic [1:0]              done;
		logic [`BERT_DATA_W-1:0] exp_byte;
		int                      l;
		@(posedge clk);
		#1;
		// Busy set the cycle after start, done wins a tie
		m_busy = (m_busy | start_last) & ~done_last;
		apply_write(pend[1]);

		check_bit("rd_valid", pend[1].rd, rd_valid);
		rd_seen = pend[1].rd;
		rd_last = rd_data;
		if (pend[1].rd) begin
			exp_byte = rd_expect.pop_front();
			check_byte("rd_data", exp_byte, rd_data);
		end
		check_bit("serdes_config_updated", m_upd, serdes_config_updated);
		check_bit("drp_lane0_en", m_start[0], drp_lane0_en);
		check_bit("drp_lane1_en", m_start[1], drp_lane1_en);
		check_tx("tx0_config", m_tx[0], tx0_config);
		check_tx("tx1_config", m_tx[1], tx1_config);
		check_rx("rx0_config", m_rx[0], rx0_config);
		check_rx("rx1_config", m_rx[1], rx1_config);
		check_drp(m_addr, m_wdata, m_we);

		// Protocol assertions of the bound checker
		if (i_bert_mgmt_top.i_sva.failures != 0) begin
			$display("Assertion in bert_mgmt_sva failed before %0t ns", $time);
			$display("test failed");
			$fatal(1);
		end

		// DRP responder, done 1 to 8 cycles after a start
		done = 2'b00;
		for (l = 0; l < 2; l++) begin
			if (resp_cnt[l] > 0) begin
				resp_cnt[l]--;
				done[l] = (resp_cnt[l] == 0);
			end
		end
		if (done[0])
			drp_lane0_rdata = 16'($urandom);
		if (done[1])
			drp_lane1_rdata = 16'($urandom);
		if (drp_lane0_en)
			resp_cnt[0] = $urandom_range(1, 8);
		if (drp_lane1_en)
			resp_cnt[1] = $urandom_range(1, 8);
		start_last = m_start;
		done_last  = done;

		// Next request
		req.rd           = do_rd;
		req.raddr        = raddr;
		req.wr           = do_wr;
		req.waddr        = waddr;
		req.wdata        = wdata;
		pend[1]          = pend[0];
		pend[0]          = req;
		rd_en            = do_rd;
		rd_addr          = raddr;
		wr_en            = do_wr;
		wr_addr          = waddr;
		wr_data          = wdata;
		drp_lane0_done   = done[0];
		drp_lane1_done   = done[1];
		lane0_rx_rstdone = 1'($urandom);
		lane1_rx_rstdone = 1'($urandom);
		// Read sampled at the last edge sees the inputs just driven
		if (pend[1].rd)
			rd_expect.push_back(expect_read(pend[1].raddr));
	endtask

	function automatic logic traffic_quiet();
		return (rd_expect.size() == 0) && !pend[0].rd && !pend[0].wr
			&& !pend[1].rd && !pend[1].wr && (resp_cnt[0] == 0) && (resp_cnt[1] == 0)
			&& (m_busy == 2'b00) && (start_last == 2'b00);
	endfunction

	// Idle bus until reads and DRP transactions are done
	task automatic drain_traffic();
		int n;
		n = 0;
		while (!traffic_quiet() && n < 50) begin
			run_cycle(1'b0, '0, 1'b0, '0, '0);
			n++;
		end
		if (!traffic_quiet())
			stop_on_timeout("bus and DRP traffic did not drain");
	endtask

	// Full DRP command on one lane, then poll STAT until busy clears
	task automatic issue_drp_command(input logic lane);
		logic [`BERT_ADDR_W-1:0] base;
		logic                    saw_busy;
		logic                    cleared;
		int                      n;
		base = lane ? 16'h00A0 : 16'h0080;
		run_cycle(1'b0, '0, 1'b1, base + 16'h04, 8'($urandom));
		run_cycle(1'b0, '0, 1'b1, base + 16'h05, 8'($urandom));
		run_cycle(1'b0, '0, 1'b1, base + 16'h06, 8'($urandom));
		run_cycle(1'b0, '0, 1'b1, base + 16'h07, 8'($urandom));
		saw_busy = 1'b0;
		cleared  = 1'b0;
		n        = 0;
		while (!cleared && n < 40) begin
			run_cycle(1'b1, base + 16'h0A, 1'b0, '0, '0);
			if (rd_seen && rd_last[0])
				saw_busy = 1'b1;
			cleared = saw_busy && rd_seen && !rd_last[0];
			n++;
		end
		if (!cleared)
			stop_on_timeout("STAT busy did not set and clear after a DRP start");
		// Returned data, back to back
		run_cycle(1'b1, base + 16'h08, 1'b0, '0, '0);
		run_cycle(1'b1, base + 16'h09, 1'b0, '0, '0);
		drain_traffic();
	endtask

	////////////////////
	// Test sequence

	initial begin
		int                      n;
		logic                    do_rd;
		logic                    do_wr;
		logic [`BERT_ADDR_W-1:0] ra;
		logic [`BERT_ADDR_W-1:0] wa;
		void'($urandom(32'h7862));
		rst              = 1'b1;
		rd_en            = 1'b0;
		rd_addr          = '0;
		wr_en            = 1'b0;
		wr_addr          = '0;
		wr_data          = '0;
		drp_lane0_rdata  = 16'($urandom);
		drp_lane1_rdata  = 16'($urandom);
		drp_lane0_done   = 1'b0;
		drp_lane1_done   = 1'b0;
		lane0_rx_rstdone = 1'b0;
		lane1_rx_rstdone = 1'b0;
		pend[0]          = '0;
		pend[1]          = '0;
		m_tx[0]          = '0;
		m_tx[1]          = '0;
		m_rx[0]          = '0;
		m_rx[1]          = '0;
		m_upd            = 1'b0;
		m_start          = 2'b00;
		m_busy           = 2'b00;
		m_we             = 1'b0;
		m_addr           = '0;
		m_wdata          = '0;
		start_last       = 2'b00;
		done_last        = 2'b00;
		resp_cnt[0]      = 0;
		resp_cnt[1]      = 0;
		rd_seen          = 1'b0;
		rd_last          = '0;

		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;
		// Reset state, the rest is compared on the first cycle
		check_byte("rd_data", '0, rd_data);

		// Random mix of reads and writes, often in the same cycle
		for (n = 0; n < 4000; n++) begin
			do_rd = 1'($urandom_range(0, 1));
			ra    = pick_addr();
			do_wr = ($urandom_range(0, 9) < 6);
			wa    = pick_addr();
			run_cycle(do_rd, ra, do_wr, wa, 8'($urandom));
		end
		drain_traffic();

		// Directed DRP commands on each lane
		issue_drp_command(1'b0);
		issue_drp_command(1'b1);

		if (i_bert_mgmt_top.i_sva.failures == 0) begin
			$display("test passed");
			$finish;
		end else begin
			$display("%0d assertion failures", i_bert_mgmt_top.i_sva.failures);
			$display("test failed");
			$fatal(1);
		end
	end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+design
design/bert_pkg.sv
design/reg_access_if.sv
design/reg_bus_decoder.sv
design/lane_config_bank.sv
design/drp_bridge.sv
design/readback_mux.sv
design/bert_mgmt_top.sv
verif/bert_mgmt_sva.sv
verif/bert_mgmt_tb.sv
